//--- disp_pkg.sv
// Dispatch stage shared definitions
// Widths, entry layout, sequencer phases and APB register map

package disp_pkg;

   ////////////////////////////////////////
   // Dispatch memory geometry
   ////////////////////////////////////////

   localparam int DADR_W     = 11;
   localparam int DISP_DEPTH = 2048;
   localparam int UPC_W      = 14;

   // Subroutine return stack
   localparam int STACK_DEPTH = 32;
   localparam int STACK_PTR_W = 5;

   typedef logic [UPC_W-1:0] upc_t;

   // One dispatch RAM word, 17 bits, return flag on top
   typedef struct packed {
      logic dr;
      logic dp;
      logic dn;
      upc_t dpc;
   } disp_entry_t;

   // Phases of one dispatch step
   typedef enum logic [1:0] {
      IDLE,
      DECODE,
      WRITE,
      PREFETCH
   } seq_phase_t;

   ////////////////////////////////////////
   // APB register map, byte offsets
   ////////////////////////////////////////

   localparam logic [7:0] REG_IR     = 8'h00;
   localparam logic [7:0] REG_VMO    = 8'h04;
   localparam logic [7:0] REG_R      = 8'h08;
   localparam logic [7:0] REG_DMASK  = 8'h0C;
   localparam logic [7:0] REG_A      = 8'h10;
   localparam logic [7:0] REG_CMD    = 8'h14;
   localparam logic [7:0] REG_PC     = 8'h18;
   localparam logic [7:0] REG_STATUS = 8'h1C;

   // Command register bits
   localparam int CMD_GO     = 0;
   localparam int CMD_DISPWR = 1;

   // Status register fields
   localparam int STAT_BUSY      = 0;
   localparam int STAT_OVF       = 1;
   localparam int STAT_DEPTH_LSB = 8;

endpackage

//--- sync_ram.sv
// Synchronous RAM, one write port and one registered read port
// Payload type and depth set per instance

`timescale 1ns/100ps

module sync_ram #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 16
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] waddr,
   input  payload_t                 wdata,
   input  logic                     re,
   input  logic [$clog2(DEPTH)-1:0] raddr,
   output payload_t                 rdata
);

   // Storage array, contents undefined until written
   payload_t mem [DEPTH];

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   ////////////////////////////////////////
   // Read port
   ////////////////////////////////////////

   // Output register keeps last word while re is low
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[raddr];
      end
   end

endmodule

//--- dispatch_ram.sv
// Dispatch RAM
// Forms the dispatch address from IR, VMO and masked R bits,
// stores entries from A on write steps and registers the
// addressed entry for the sequencer

`timescale 1ns/100ps

module dispatch_ram import disp_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        state_prefetch,
   input  logic        state_write,
   input  logic [23:0] vmo,
   input  logic [31:0] a,
   input  logic [31:0] r,
   input  logic [48:0] ir,
   input  logic [6:0]  dmask,
   input  logic        dispwr,
   output upc_t        dpc,
   output logic        dn,
   output logic        dp,
   output logic        dr
);

   logic [DADR_W-1:0] dadr;
   logic              daddr0;
   logic              dwe;
   logic              dre;
   logic              rd_valid;
   disp_entry_t       ram_q;
   disp_entry_t       entry;

   ////////////////////////////////////////
   // Address formation
   ////////////////////////////////////////

   // Low bit merges map bits, mask bit and IR bit 12
   assign daddr0 = (ir[8] & vmo[18]) | (ir[9] & vmo[19]) | (dmask[0] & r[0]) | ir[12];

   // IR field on top, masked R bits ORed into bits 6..1
   assign dadr = {ir[22:13], daddr0} | {4'b0000, dmask[6:1] & r[6:1], 1'b0};

   ////////////////////////////////////////
   // Port enables
   ////////////////////////////////////////

   // Store only in WRITE phase of a write step
   assign dwe = dispwr & state_write;

   // Capture entry outside prefetch and write phases
   assign dre = ~state_prefetch & ~state_write;

   sync_ram #(
      .payload_t (disp_entry_t),
      .DEPTH     (DISP_DEPTH)
   ) i_ram (
      .clk   (clk),
      .we    (dwe),
      .waddr (dadr),
      .wdata (disp_entry_t'(a[16:0])),
      .re    (dre),
      .raddr (dadr),
      .rdata (ram_q)
   );

   // Entry reads zero until the first capture after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else if (dre) begin
         rd_valid <= 1'b1;
      end
   end

   assign entry = rd_valid ? ram_q : '0;

   // Unpack entry fields
   assign dpc = entry.dpc;
   assign dn  = entry.dn;
   assign dp  = entry.dp;
   assign dr  = entry.dr;

   // Prefetch always uses an entry captured the cycle before
   a_fresh_entry : assert property (@(posedge clk) disable iff (reset)
      state_prefetch |-> $past(dre));

endmodule

//--- return_stack.sv
// Subroutine return-address stack
// 32 entries in a synchronous RAM plus a registered top entry,
// so a pop shows the return address in the same cycle

`timescale 1ns/100ps

module return_stack import disp_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 push,
   input  logic                 pop,
   input  upc_t                 push_data,
   output upc_t                 top,
   output logic [STACK_PTR_W:0] depth,
   output logic                 empty,
   output logic                 overflow
);

   logic [STACK_PTR_W:0]   depth_nxt;
   logic [STACK_PTR_W-1:0] rd_addr;
   logic                   full;
   logic                   do_push;
   logic                   do_pop;
   upc_t                   second;
   upc_t                   top_q;

   assign full    = (depth == (STACK_PTR_W+1)'(STACK_DEPTH));
   assign empty   = (depth == '0);
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   always_comb begin
      depth_nxt = depth;
      if (do_push) begin
         depth_nxt = depth + 1'b1;
      end else if (do_pop) begin
         depth_nxt = depth - 1'b1;
      end
   end

   // Read port tracks the entry below the new top
   assign rd_addr = depth_nxt[STACK_PTR_W-1:0] - STACK_PTR_W'(2);

   sync_ram #(
      .payload_t (upc_t),
      .DEPTH     (STACK_DEPTH)
   ) i_mem (
      .clk   (clk),
      .we    (do_push),
      .waddr (depth[STACK_PTR_W-1:0]),
      .wdata (push_data),
      .re    (1'b1),
      .raddr (rd_addr),
      .rdata (second)
   );

   ////////////////////////////////////////
   // Pointer, top copy, overflow flag
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         depth    <= '0;
         top_q    <= '0;
         overflow <= 1'b0;
      end else begin
         depth <= depth_nxt;
         if (do_push) begin
            top_q <= push_data;
         end else if (do_pop) begin
            // Last entry gone, top reads zero
            top_q <= (depth == 1) ? '0 : second;
         end
         // Sticky, push onto a full stack is dropped
         if (push && full) begin
            overflow <= 1'b1;
         end
      end
   end

   assign top = top_q;

   // Sequencer only ever calls or returns, never both
   a_no_push_pop : assert property (@(posedge clk) disable iff (reset)
      !(push && pop));

endmodule

//--- micro_sequencer.sv
// Micro-sequencer for the dispatch stage
// Walks the phases of each step and, in PREFETCH, picks the
// next micro-PC from the dispatch entry and the return stack

`timescale 1ns/100ps

module micro_sequencer import disp_pkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic step_start,
   input  logic step_write,
   input  logic pc_load,
   input  upc_t pc_load_value,
   input  upc_t dpc,
   input  logic dn,
   input  logic dp,
   input  logic dr,
   input  upc_t stack_top,
   input  logic stack_empty,
   output logic state_prefetch,
   output logic state_write,
   output logic dispwr,
   output logic push,
   output logic pop,
   output upc_t push_data,
   output upc_t upc,
   output logic busy,
   output logic step_done
);

   seq_phase_t phase;
   seq_phase_t phase_nxt;
   upc_t       upc_inc;
   upc_t       upc_nxt;

   assign state_prefetch = (phase == PREFETCH);
   assign state_write    = (phase == WRITE);
   assign busy           = (phase != IDLE);

   ////////////////////////////////////////
   // Next micro-PC
   ////////////////////////////////////////

   assign upc_inc   = upc + UPC_W'(1);
   assign push_data = upc_inc;

   // Call pushes return address, return pops when something is there
   assign push = state_prefetch & ~dn & ~dr & dp;
   assign pop  = state_prefetch & ~dn & dr & ~stack_empty;

   always_comb begin
      if (dn) begin
         upc_nxt = upc_inc;
      end else if (dr) begin
         upc_nxt = stack_empty ? upc_inc : stack_top;
      end else begin
         upc_nxt = dpc;
      end
   end

   ////////////////////////////////////////
   // Phase walk
   ////////////////////////////////////////

   always_comb begin
      phase_nxt = phase;
      case (phase)
         IDLE: begin
            if (step_start) begin
               phase_nxt = step_write ? WRITE : DECODE;
            end
         end
         DECODE:   phase_nxt = PREFETCH;
         PREFETCH: phase_nxt = IDLE;
         WRITE:    phase_nxt = IDLE;
         default:  phase_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         phase     <= IDLE;
         dispwr    <= 1'b0;
         step_done <= 1'b0;
         upc       <= '0;
      end else begin
         phase     <= phase_nxt;
         // Last phase of either step
         step_done <= state_prefetch | state_write;
         if (step_start) begin
            dispwr <= step_write;
         end
         if (pc_load) begin
            upc <= pc_load_value;
         end else if (state_prefetch) begin
            upc <= upc_nxt;
         end
      end
   end

   // Host interface holds new commands back until the step ends
   a_start_when_idle : assert property (@(posedge clk) disable iff (reset)
      step_start |-> !busy);

endmodule

//--- apb_regs.sv
// APB slave for the dispatch stage
// Operand registers, command and PC load pulses, status readback,
// wait states on CMD and PC while a step runs

`timescale 1ns/100ps

module apb_regs import disp_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [7:0]           paddr,
   input  logic [31:0]          pwdata,
   output logic [31:0]          prdata,
   output logic                 pready,
   output logic                 pslverr,
   output logic [48:0]          ir,
   output logic [23:0]          vmo,
   output logic [31:0]          r,
   output logic [6:0]           dmask,
   output logic [31:0]          a,
   output logic                 step_start,
   output logic                 step_write,
   output logic                 pc_load,
   output upc_t                 pc_load_value,
   input  upc_t                 upc,
   input  logic                 busy,
   input  logic [STACK_PTR_W:0] depth,
   input  logic                 overflow
);

   logic [31:0] ir_q;
   logic        access;
   logic        mapped;
   logic        ctrl_reg;
   logic        wr_en;
   logic        step_busy;

   // Access phase of a transfer
   assign access = psel & penable;

   assign mapped = (paddr[1:0] == 2'b00) && (paddr <= REG_STATUS);
   assign ctrl_reg = (paddr == REG_CMD) || (paddr == REG_PC);

   // Step requested or still running
   assign step_busy = busy | step_start;

   assign pready  = ~(access & ctrl_reg & step_busy);
   assign pslverr = access & ~mapped;
   assign wr_en   = access & pready & pwrite & mapped;

   assign ir = {17'b0, ir_q};

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         ir_q       <= '0;
         vmo        <= '0;
         r          <= '0;
         dmask      <= '0;
         a          <= '0;
         step_start <= 1'b0;
         step_write <= 1'b0;
         pc_load    <= 1'b0;
      end else begin
         // Single-cycle pulses
         step_start <= 1'b0;
         pc_load    <= 1'b0;
         if (wr_en) begin
            case (paddr)
               REG_IR:    ir_q  <= pwdata;
               REG_VMO:   vmo   <= pwdata[23:0];
               REG_R:     r     <= pwdata;
               REG_DMASK: dmask <= pwdata[6:0];
               REG_A:     a     <= pwdata;
               REG_CMD: begin
                  step_start <= pwdata[CMD_GO];
                  step_write <= pwdata[CMD_DISPWR];
               end
               REG_PC:    pc_load <= 1'b1;
               default:   ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en && (paddr == REG_PC)) begin
         pc_load_value <= pwdata[UPC_W-1:0];
      end
   end

   ////////////////////////////////////////
   // Readback
   ////////////////////////////////////////

   always_comb begin
      prdata = '0;
      case (paddr)
         REG_IR:    prdata = ir_q;
         REG_VMO:   prdata = {8'b0, vmo};
         REG_R:     prdata = r;
         REG_DMASK: prdata = {25'b0, dmask};
         REG_A:     prdata = a;
         REG_PC:    prdata = 32'(upc);
         REG_STATUS: begin
            prdata[STAT_BUSY] = step_busy;
            prdata[STAT_OVF]  = overflow;
            prdata[STAT_DEPTH_LSB +: STACK_PTR_W+1] = depth;
         end
         // CMD is write only
         default:   prdata = '0;
      endcase
   end

   // Access follows setup or a stalled access
   a_apb_setup : assert property (@(posedge clk) disable iff (reset)
      (psel && penable) |-> $past(psel && (!penable || !pready)));

endmodule

//--- dispatch_top.sv
// Dispatch stage top level
// APB register block, micro-sequencer, dispatch RAM and return stack

`timescale 1ns/100ps

module dispatch_top import disp_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr
);

   // Operand registers
   logic [48:0] ir;
   logic [23:0] vmo;
   logic [31:0] r;
   logic [6:0]  dmask;
   logic [31:0] a;

   // Step control
   logic step_start;
   logic step_write;
   logic pc_load;
   upc_t pc_load_value;
   logic state_prefetch;
   logic state_write;
   logic dispwr;
   logic busy;
   logic step_done;
   upc_t upc;

   // Dispatch entry
   upc_t dpc;
   logic dn;
   logic dp;
   logic dr;

   // Return stack
   logic                 push;
   logic                 pop;
   upc_t                 push_data;
   upc_t                 stack_top;
   logic [STACK_PTR_W:0] depth;
   logic                 stack_empty;
   logic                 overflow;

   apb_regs i_apb (
      .clk           (clk),
      .reset         (reset),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .ir            (ir),
      .vmo           (vmo),
      .r             (r),
      .dmask         (dmask),
      .a             (a),
      .step_start    (step_start),
      .step_write    (step_write),
      .pc_load       (pc_load),
      .pc_load_value (pc_load_value),
      .upc           (upc),
      .busy          (busy),
      .depth         (depth),
      .overflow      (overflow)
   );

   micro_sequencer i_seq (
      .clk            (clk),
      .reset          (reset),
      .step_start     (step_start),
      .step_write     (step_write),
      .pc_load        (pc_load),
      .pc_load_value  (pc_load_value),
      .dpc            (dpc),
      .dn             (dn),
      .dp             (dp),
      .dr             (dr),
      .stack_top      (stack_top),
      .stack_empty    (stack_empty),
      .state_prefetch (state_prefetch),
      .state_write    (state_write),
      .dispwr         (dispwr),
      .push           (push),
      .pop            (pop),
      .push_data      (push_data),
      .upc            (upc),
      .busy           (busy),
      .step_done      (step_done)
   );

   dispatch_ram i_dram (
      .clk            (clk),
      .reset          (reset),
      .state_prefetch (state_prefetch),
      .state_write    (state_write),
      .vmo            (vmo),
      .a              (a),
      .r              (r),
      .ir             (ir),
      .dmask          (dmask),
      .dispwr         (dispwr),
      .dpc            (dpc),
      .dn             (dn),
      .dp             (dp),
      .dr             (dr)
   );

   return_stack i_stack (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .pop       (pop),
      .push_data (push_data),
      .top       (stack_top),
      .depth     (depth),
      .empty     (stack_empty),
      .overflow  (overflow)
   );

   // Stack depth moves only as a read step completes
   a_depth_at_done : assert property (@(posedge clk) disable iff (reset)
      $changed(depth) |-> step_done);

endmodule

//--- dispatch_checker.sv
// Dispatch stage checker
// Follows completed APB transfers, keeps a reference model of the
// dispatch memory, return stack and micro-PC, compares PC and
// STATUS reads and PSLVERR on every transfer

`timescale 1ns/100ps

module dispatch_checker import disp_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   input  logic [31:0] prdata,
   input  logic        pready,
   input  logic        pslverr,
   output int          errors,
   output int          checks
);

   // Reference state
   disp_entry_t          mem_m [DISP_DEPTH];
   upc_t                 stk_m [STACK_DEPTH];
   logic [STACK_PTR_W:0] depth_m;
   logic                 ovf_m;
   upc_t                 pc_m;
   logic [31:0]          ir_m;
   logic [23:0]          vmo_m;
   logic [31:0]          r_m;
   logic [6:0]           dmask_m;
   logic [31:0]          a_m;

   // Cycles the DUT still shows busy
   int                   busy_left;
   logic                 busy_m;

   ////////////////////////////////////////
   // Reference functions
   ////////////////////////////////////////

   function automatic logic [DADR_W-1:0] dispatch_address(logic [31:0] ir, logic [23:0] vmo,
                                                          logic [31:0] r, logic [6:0] dmask);
      logic              low;
      logic [DADR_W-1:0] adr;
      low = (ir[8] & vmo[18]) | (ir[9] & vmo[19]) | (dmask[0] & r[0]) | ir[12];
      adr = {ir[22:13], low};
      // Masked R bits merge into the middle field
      adr[6:1] = adr[6:1] | (dmask[6:1] & r[6:1]);
      return adr;
   endfunction

   function automatic upc_t next_pc(disp_entry_t e, upc_t pc, logic empty, upc_t top);
      if (e.dn) begin
         return pc + UPC_W'(1);
      end
      if (e.dr) begin
         return empty ? pc + UPC_W'(1) : top;
      end
      return e.dpc;
   endfunction

   function automatic logic offset_mapped(logic [7:0] off);
      return (off[1:0] == 2'b00) && (off <= 8'h1C);
   endfunction

   // Expected STATUS word
   function automatic logic [31:0] status_word(logic busy, logic [STACK_PTR_W:0] depth,
                                               logic ovf);
      logic [31:0] w;
      w = '0;
      w[STAT_BUSY] = busy;
      w[STAT_OVF] = ovf;
      w[STAT_DEPTH_LSB +: STACK_PTR_W+1] = depth;
      return w;
   endfunction

   ////////////////////////////////////////
   // Model updates
   ////////////////////////////////////////

   task automatic read_step();
      disp_entry_t            e;
      upc_t                   top;
      upc_t                   nxt;
      logic [STACK_PTR_W-1:0] sp;
      sp  = depth_m[STACK_PTR_W-1:0] - STACK_PTR_W'(1);
      e   = mem_m[dispatch_address(ir_m, vmo_m, r_m, dmask_m)];
      top = (depth_m != '0) ? stk_m[sp] : '0;
      nxt = next_pc(e, pc_m, depth_m == '0, top);
      if (!e.dn && e.dr && depth_m != '0) begin
         depth_m = depth_m - 1'b1;
      end else if (!e.dn && !e.dr && e.dp) begin
         // Full stack drops the call and sets overflow
         if (depth_m < (STACK_PTR_W+1)'(STACK_DEPTH)) begin
            stk_m[depth_m[STACK_PTR_W-1:0]] = pc_m + UPC_W'(1);
            depth_m = depth_m + 1'b1;
         end else begin
            ovf_m = 1'b1;
         end
      end
      pc_m = nxt;
   endtask

   task automatic apply_write();
      case (paddr)
         REG_IR:    ir_m    = pwdata;
         REG_VMO:   vmo_m   = pwdata[23:0];
         REG_R:     r_m     = pwdata;
         REG_DMASK: dmask_m = pwdata[6:0];
         REG_A:     a_m     = pwdata;
         REG_PC:    pc_m    = pwdata[UPC_W-1:0];
         REG_CMD: begin
            if (pwdata[CMD_GO] && pwdata[CMD_DISPWR]) begin
               mem_m[dispatch_address(ir_m, vmo_m, r_m, dmask_m)] = disp_entry_t'(a_m[16:0]);
               // Start pulse, then WRITE
               busy_left = 2;
            end else if (pwdata[CMD_GO]) begin
               read_step();
               // Start pulse, DECODE and PREFETCH
               busy_left = 3;
            end
         end
         default: ;
      endcase
   endtask

   task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   ////////////////////////////////////////
   // Transfer monitor
   ////////////////////////////////////////

   always @(posedge clk) begin
      if (reset) begin
         errors    = 0;
         checks    = 0;
         pc_m      = '0;
         depth_m   = '0;
         ovf_m     = 1'b0;
         ir_m      = '0;
         vmo_m     = '0;
         r_m       = '0;
         dmask_m   = '0;
         a_m       = '0;
         busy_left = 0;
         busy_m    = 1'b0;
      end else begin
         // Busy as shown in the cycle ending at this edge
         busy_m = (busy_left != 0);
         if (busy_left != 0) begin
            busy_left--;
         end
         if (psel && penable && pready) begin
            compare("PSLVERR", {31'b0, pslverr}, {31'b0, !offset_mapped(paddr)});
            if (offset_mapped(paddr)) begin
               if (pwrite) begin
                  apply_write();
               end else if (paddr == REG_PC) begin
                  compare("PC", prdata, 32'(pc_m));
               end else if (paddr == REG_STATUS) begin
                  compare("STATUS", prdata, status_word(busy_m, depth_m, ovf_m));
               end
            end
         end
      end
   end

endmodule

//--- dispatch_tb.sv
// Testbench for the dispatch stage
// Drives the APB port through reset, dispatch, inhibit, call and
// return, overflow and back-pressure tests

`timescale 1ns/100ps

module dispatch_tb import disp_pkg::*; ();

   localparam int N_RAND         = 200;
   localparam int N_XFERS        = DISP_DEPTH * 3 + N_RAND * 6 + 800;
   localparam int TIMEOUT_CYCLES = N_XFERS * 10 + 1000;

   logic        clk = 1'b0;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   int          seed = 32'haa1aa1ff;
   logic [31:0] rnd;
   int          tb_errors = 0;
   int          test_num = 0;
   int          errors_before = 0;
   int          cycles = 0;
   int          chk_errors;
   int          chk_checks;

   // 8 ns clock
   always #4 clk = ~clk;

   dispatch_top i_dut (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   dispatch_checker i_check (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .errors  (chk_errors),
      .checks  (chk_checks)
   );

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // APB master tasks
   ////////////////////////////////////////

   // Stall counts access cycles with pready low
   task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                               input logic [31:0] wdata, output int stall);
      stall   = 0;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      while (!pready) begin
         stall++;
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      int stall;
      apb_transfer(1'b1, addr, data, stall);
   endtask

   task automatic apb_read(input logic [7:0] addr);
      int stall;
      apb_transfer(1'b0, addr, 32'h0, stall);
   endtask

   function automatic logic [31:0] cmd_word(input logic dispwr);
      logic [31:0] w;
      w = '0;
      w[CMD_GO]     = 1'b1;
      w[CMD_DISPWR] = dispwr;
      return w;
   endfunction

   // IR value that selects an address when VMO, R and DMASK are zero
   function automatic logic [31:0] ir_for(input logic [DADR_W-1:0] adr);
      return {9'b0, adr, 12'b0};
   endfunction

   function automatic logic [31:0] make_entry(input logic dr, input logic dp,
                                              input logic dn, input upc_t dpc);
      return {15'b0, dr, dp, dn, dpc};
   endfunction

   task automatic clear_operands();
      apb_write(REG_VMO, 32'h0);
      apb_write(REG_R, 32'h0);
      apb_write(REG_DMASK, 32'h0);
   endtask

   task automatic write_entry(input logic [DADR_W-1:0] adr, input logic [31:0] entry);
      apb_write(REG_IR, ir_for(adr));
      apb_write(REG_A, entry);
      apb_write(REG_CMD, cmd_word(1'b1));
   endtask

   // PC read waits out the step, so STATUS then sees it idle
   task automatic dispatch_at(input logic [DADR_W-1:0] adr);
      apb_write(REG_IR, ir_for(adr));
      apb_write(REG_CMD, cmd_word(1'b0));
      apb_read(REG_PC);
      apb_read(REG_STATUS);
   endtask

   task automatic end_test(input string name);
      int total;
      total = chk_errors + tb_errors;
      test_num++;
      $display("Test %0d, %s: %0d errors", test_num, name, total - errors_before);
      errors_before = total;
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      int stall;
      reset   = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;

      apb_read(REG_PC);
      apb_read(REG_STATUS);
      end_test("reset state");

      // Fill the whole RAM so every random address holds an entry
      clear_operands();
      for (int i = 0; i < DISP_DEPTH; i++) begin
         rnd = $random(seed);
         write_entry(DADR_W'(i), make_entry(1'b0, 1'b0, 1'b0, rnd[UPC_W-1:0]));
      end
      for (int i = 0; i < N_RAND; i++) begin
         rnd = $random(seed);
         apb_write(REG_IR, rnd);
         rnd = $random(seed);
         apb_write(REG_VMO, {8'b0, rnd[23:0]});
         rnd = $random(seed);
         apb_write(REG_R, rnd);
         rnd = $random(seed);
         apb_write(REG_DMASK, {25'b0, rnd[6:0]});
         apb_write(REG_CMD, cmd_word(1'b0));
         apb_read(REG_PC);
      end
      end_test("address formation and plain dispatch");

      // dn wins over dp, dr and dpc
      clear_operands();
      for (int i = 0; i < 8; i++) begin
         rnd = $random(seed);
         write_entry(11'd4, make_entry(rnd[31], rnd[30], 1'b1, rnd[UPC_W-1:0]));
         rnd = $random(seed);
         apb_write(REG_PC, {18'b0, rnd[UPC_W-1:0]});
         dispatch_at(11'd4);
      end
      end_test("inhibit");

      // Two calls, then returns down past an empty stack
      write_entry(11'd1, make_entry(1'b0, 1'b1, 1'b0, 14'h0200));
      write_entry(11'd2, make_entry(1'b0, 1'b1, 1'b0, 14'h0300));
      write_entry(11'd3, make_entry(1'b1, 1'b0, 1'b0, 14'h3fff));
      apb_write(REG_PC, 32'h0000_0100);
      dispatch_at(11'd1);
      dispatch_at(11'd2);
      dispatch_at(11'd3);
      dispatch_at(11'd3);
      dispatch_at(11'd3);
      end_test("call and return");

      for (int i = 0; i < STACK_DEPTH + 1; i++) begin
         dispatch_at(11'd1);
      end
      end_test("stack overflow");

      // Second GO arrives while the first step runs
      write_entry(11'd5, make_entry(1'b0, 1'b0, 1'b1, 14'h1234));
      apb_write(REG_IR, ir_for(11'd5));
      apb_write(REG_PC, 32'h0000_0040);
      apb_write(REG_CMD, cmd_word(1'b0));
      apb_transfer(1'b1, REG_CMD, cmd_word(1'b0), stall);
      if (stall == 0) begin
         tb_errors++;
         $display("Error at %0t ns: CMD write during a step saw no wait states", $time);
      end
      // STATUS read lands inside the second step
      apb_read(REG_STATUS);
      apb_read(REG_PC);
      apb_read(REG_STATUS);
      apb_read(8'h20);
      apb_write(8'h06, 32'hdead_beef);
      apb_read(8'hF0);
      end_test("back-pressure and unmapped offsets");

      $display("Tests: %0d, checks: %0d, errors: %0d",
               test_num, chk_checks, chk_errors + tb_errors);
      if (chk_errors + tb_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- tb.f
disp_pkg.sv
sync_ram.sv
dispatch_ram.sv
return_stack.sv
micro_sequencer.sv
apb_regs.sv
dispatch_top.sv
dispatch_checker.sv
dispatch_tb.sv

//--- Makefile
# Verilator build and run for the dispatch stage testbench

all: run

obj_dir/Vdispatch_tb: tb.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 --top-module dispatch_tb -f tb.f -o Vdispatch_tb

run: obj_dir/Vdispatch_tb
	./obj_dir/Vdispatch_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
